//--- Bender.yml
package:
  name: mesh_rx

sources:
  # Package first, then leaf modules, then the top level
  - rtl/mesh_pkg.sv
  - rtl/rx_mmu.sv
  - rtl/rx_distributor.sv
  - rtl/rx_fifo.sv
  - rtl/rx_top.sv

  # Bound assertions and the testbench
  - target: test
    files:
      - sim/rx_top_asserts.sv
      - sim/tb_rx_top.sv

__END__

//--- project.f
rtl/mesh_pkg.sv
rtl/rx_mmu.sv
rtl/rx_distributor.sv
rtl/rx_fifo.sv
rtl/rx_top.sv
sim/rx_top_asserts.sv
sim/tb_rx_top.sv

//--- rtl/mesh_pkg.sv
// ======================================================================
// Mesh receive definitions
// Packet layout, address field types and the constants of this link
// ======================================================================

`default_nettype none

package mesh_pkg;

  // Field widths
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int LINK_ID_W    = 12;
  localparam int PAGE_INDEX_W = 4;

  // Full destination or source address
  typedef logic [ADDR_W-1:0] mesh_addr_t;

  // Write data or read return data
  typedef logic [DATA_W-1:0] mesh_data_t;

  // Upper address field, names a link or mesh node
  typedef logic [LINK_ID_W-1:0] link_id_t;

  // Remap table index, destination bits 31 to 28
  typedef logic [PAGE_INDEX_W-1:0] page_index_t;

  // Mesh transaction, 103 bits
  // Write bit sits at the top, source address at the bottom
  typedef struct packed {
    logic       write;
    logic [1:0] datamode;
    logic [3:0] ctrlmode;
    mesh_addr_t dstaddr;
    mesh_data_t data;
    mesh_addr_t srcaddr;
  } mesh_packet_t;

  // Own ID of this link
  localparam link_id_t LINK_ID = 12'h800;

  // Destination bits 19 to 16 for a read response to this link
  localparam logic [3:0] READTAG_GROUP = 4'h3;

  // Number of remap table entries
  localparam int MAP_ENTRIES = 16;

  // Depth of each output queue
  localparam int FIFO_DEPTH = 4;

endpackage

`default_nettype wire

//--- rtl/rx_distributor.sv
// ======================================================================
// Receive transaction distributor
// Sorts MMU and DMA packets into write, read and read-response streams
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module rx_distributor (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mmu_valid,
  output logic                   mmu_ready,
  input  mesh_pkg::mesh_packet_t mmu_packet,
  input  logic                   dma_valid,
  output logic                   dma_ready,
  input  mesh_pkg::mesh_packet_t dma_packet,
  output logic                   wr_valid,
  input  logic                   wr_ready,
  output mesh_pkg::mesh_packet_t wr_packet,
  output logic                   rd_valid,
  input  logic                   rd_ready,
  output mesh_pkg::mesh_packet_t rd_packet,
  output logic                   rr_valid,
  input  logic                   rr_ready,
  output mesh_pkg::mesh_packet_t rr_packet
);

  // Classification of the MMU packet
  logic own_link;
  logic readtag_hit;
  logic is_rd;
  logic is_wr;
  logic is_rr;

  // Output registers able to take a new packet
  logic wr_can;
  logic rd_can;
  logic rr_can;

  // Transfers per destination
  logic mmu_fire;
  logic mmu_rd_fire;
  logic mmu_wr_fire;
  logic mmu_rr_fire;
  logic dma_fire;

  assign own_link    = (mmu_packet.dstaddr[31:20] == mesh_pkg::LINK_ID);
  assign readtag_hit = (mmu_packet.dstaddr[19:16] == mesh_pkg::READTAG_GROUP);

  // Read requests, pass-through writes, read responses
  // Other writes to this link fall through and are dropped
  assign is_rd = ~mmu_packet.write;
  assign is_wr = mmu_packet.write & ~own_link;
  assign is_rr = mmu_packet.write & own_link & readtag_hit;

  // Register is free or being emptied this cycle
  assign wr_can = ~wr_valid | wr_ready;
  assign rd_can = ~rd_valid | rd_ready;
  assign rr_can = ~rr_valid | rr_ready;

  // MMU side waits only on its own target
  always_comb
  begin
    if (is_rd)
      mmu_ready = rd_can;
    else if (is_wr)
      mmu_ready = wr_can;
    else if (is_rr)
      mmu_ready = rr_can;
    else
      mmu_ready = 1'b1;
  end

  // Pending mesh read takes the rd register first
  assign dma_ready = rd_can & ~(mmu_valid & is_rd);

  assign mmu_fire    = mmu_valid & mmu_ready;
  assign mmu_rd_fire = mmu_fire & is_rd;
  assign mmu_wr_fire = mmu_fire & is_wr;
  assign mmu_rr_fire = mmu_fire & is_rr;
  assign dma_fire    = dma_valid & dma_ready;

  // Valid flags, set on load, cleared on drain
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_valid <= 1'b0;
      rd_valid <= 1'b0;
      rr_valid <= 1'b0;
    end
    else
    begin
      if (wr_can)
        wr_valid <= mmu_wr_fire;
      if (rd_can)
        rd_valid <= mmu_rd_fire | dma_fire;
      if (rr_can)
        rr_valid <= mmu_rr_fire;
    end
  end

  // Payload registers
  always_ff @(posedge clk)
  begin
    if (mmu_wr_fire)
      wr_packet <= mmu_packet;
    if (mmu_rr_fire)
      rr_packet <= mmu_packet;
    // Mesh read wins, DMA otherwise
    if (mmu_rd_fire)
      rd_packet <= mmu_packet;
    else if (dma_fire)
      rd_packet <= dma_packet;
  end

endmodule

`default_nettype wire

//--- rtl/rx_fifo.sv
// ======================================================================
// Receive stream queue
// Circular buffer with valid/ready on both sides
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module rx_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  mesh_pkg::mesh_packet_t in_packet,
  output logic                   out_valid,
  input  logic                   out_ready,
  output mesh_pkg::mesh_packet_t out_packet
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage
  mesh_pkg::mesh_packet_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic push;
  logic pop;

  assign full = (count == CNT_W'(DEPTH));

  // Full queue still takes a write alongside a read
  assign in_ready  = ~full | out_ready;
  assign out_valid = (count != '0);
  assign out_packet = mem[rd_ptr];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Pointers and occupancy
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      // Simultaneous push and pop leave count alone
      if (push & ~pop)
        count <= count + 1'b1;
      else if (pop & ~push)
        count <= count - 1'b1;
    end
  end

  // Entry write
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= in_packet;
  end

endmodule

`default_nettype wire

//--- rtl/rx_mmu.sv
// ======================================================================
// Receive address translation
// 16-entry page remap of destination bits 31 to 20, one register stage
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module rx_mmu (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mmu_en,
  input  logic                   map_we,
  input  mesh_pkg::page_index_t  map_index,
  input  mesh_pkg::link_id_t     map_page,
  input  logic                   in_valid,
  output logic                   in_ready,
  input  mesh_pkg::mesh_packet_t in_packet,
  output logic                   out_valid,
  input  logic                   out_ready,
  output mesh_pkg::mesh_packet_t out_packet
);

  // Remap table, one link ID per page
  mesh_pkg::link_id_t map_table [mesh_pkg::MAP_ENTRIES];

  // Translated version of the incoming packet
  mesh_pkg::mesh_packet_t xlat_packet;
  mesh_pkg::page_index_t  page;

  logic in_fire;

  // Table write port
  // Reset loads the identity mapping
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      for (int i = 0; i < mesh_pkg::MAP_ENTRIES; i++)
      begin
        map_table[i] <= {mesh_pkg::page_index_t'(i), 8'h00};
      end
    end
    else if (map_we)
    begin
      map_table[map_index] <= map_page;
    end
  end

  // Page taken from the top nibble of the destination
  assign page = in_packet.dstaddr[31:28];

  // Swap in the mapped link field when enabled
  always_comb
  begin
    xlat_packet = in_packet;
    if (mmu_en)
    begin
      xlat_packet.dstaddr[31:20] = map_table[page];
    end
  end

  // Accept when stage empty or draining this cycle
  assign in_ready = ~out_valid | out_ready;
  assign in_fire  = in_valid & in_ready;

  // Output stage valid
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      out_valid <= 1'b0;
    end
    else if (in_ready)
    begin
      out_valid <= in_valid;
    end
  end

  // Payload register, loaded only on a transfer
  always_ff @(posedge clk)
  begin
    if (in_fire)
    begin
      out_packet <= xlat_packet;
    end
  end

endmodule

`default_nettype wire

//--- rtl/rx_top.sv
// ======================================================================
// Mesh receive distributor top level
// Translation, sorting by type and three output queues
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module rx_top (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   mmu_en,
  input  logic                   map_we,
  input  mesh_pkg::page_index_t  map_index,
  input  mesh_pkg::link_id_t     map_page,
  input  logic                   mesh_in_valid,
  output logic                   mesh_in_ready,
  input  mesh_pkg::mesh_packet_t mesh_in_packet,
  input  logic                   dma_in_valid,
  output logic                   dma_in_ready,
  input  mesh_pkg::mesh_packet_t dma_in_packet,
  output logic                   wr_out_valid,
  input  logic                   wr_out_ready,
  output mesh_pkg::mesh_packet_t wr_out_packet,
  output logic                   rd_out_valid,
  input  logic                   rd_out_ready,
  output mesh_pkg::mesh_packet_t rd_out_packet,
  output logic                   rr_out_valid,
  input  logic                   rr_out_ready,
  output mesh_pkg::mesh_packet_t rr_out_packet
);

  // MMU to distributor
  logic                   mmu_valid;
  logic                   mmu_ready;
  mesh_pkg::mesh_packet_t mmu_packet;

  // Distributor to queues
  logic                   wr_valid;
  logic                   wr_ready;
  mesh_pkg::mesh_packet_t wr_packet;
  logic                   rd_valid;
  logic                   rd_ready;
  mesh_pkg::mesh_packet_t rd_packet;
  logic                   rr_valid;
  logic                   rr_ready;
  mesh_pkg::mesh_packet_t rr_packet;

  // Address translation stage
  rx_mmu i_rx_mmu (
    .clk        (clk),
    .reset      (reset),
    .mmu_en     (mmu_en),
    .map_we     (map_we),
    .map_index  (map_index),
    .map_page   (map_page),
    .in_valid   (mesh_in_valid),
    .in_ready   (mesh_in_ready),
    .in_packet  (mesh_in_packet),
    .out_valid  (mmu_valid),
    .out_ready  (mmu_ready),
    .out_packet (mmu_packet)
  );

  // Sorting by transaction type, DMA reads merged in
  rx_distributor i_rx_distributor (
    .clk        (clk),
    .reset      (reset),
    .mmu_valid  (mmu_valid),
    .mmu_ready  (mmu_ready),
    .mmu_packet (mmu_packet),
    .dma_valid  (dma_in_valid),
    .dma_ready  (dma_in_ready),
    .dma_packet (dma_in_packet),
    .wr_valid   (wr_valid),
    .wr_ready   (wr_ready),
    .wr_packet  (wr_packet),
    .rd_valid   (rd_valid),
    .rd_ready   (rd_ready),
    .rd_packet  (rd_packet),
    .rr_valid   (rr_valid),
    .rr_ready   (rr_ready),
    .rr_packet  (rr_packet)
  );

  // Remote write queue
  rx_fifo #(.DEPTH(mesh_pkg::FIFO_DEPTH)) i_wr_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (wr_valid),
    .in_ready   (wr_ready),
    .in_packet  (wr_packet),
    .out_valid  (wr_out_valid),
    .out_ready  (wr_out_ready),
    .out_packet (wr_out_packet)
  );

  // Read request queue
  rx_fifo #(.DEPTH(mesh_pkg::FIFO_DEPTH)) i_rd_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (rd_valid),
    .in_ready   (rd_ready),
    .in_packet  (rd_packet),
    .out_valid  (rd_out_valid),
    .out_ready  (rd_out_ready),
    .out_packet (rd_out_packet)
  );

  // Read response queue
  rx_fifo #(.DEPTH(mesh_pkg::FIFO_DEPTH)) i_rr_fifo (
    .clk        (clk),
    .reset      (reset),
    .in_valid   (rr_valid),
    .in_ready   (rr_ready),
    .in_packet  (rr_packet),
    .out_valid  (rr_out_valid),
    .out_ready  (rr_out_ready),
    .out_packet (rr_out_packet)
  );

endmodule

`default_nettype wire

//--- sim/rx_top_asserts.sv
// ======================================================================
// Handshake checks on the receive outputs
// Stalled outputs hold and nothing is valid in reset
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module rx_top_asserts (
  input logic                   clk,
  input logic                   reset,
  input logic                   wr_out_valid,
  input logic                   wr_out_ready,
  input mesh_pkg::mesh_packet_t wr_out_packet,
  input logic                   rd_out_valid,
  input logic                   rd_out_ready,
  input mesh_pkg::mesh_packet_t rd_out_packet,
  input logic                   rr_out_valid,
  input logic                   rr_out_ready,
  input mesh_pkg::mesh_packet_t rr_out_packet
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Stalled write stream keeps valid and payload
  wr_hold: assert property (@(posedge clk) disable iff (reset)
    wr_out_valid && !wr_out_ready |=> wr_out_valid && $stable(wr_out_packet))
    else
    begin
      $error("wr_out dropped or changed while stalled");
      fail_count++;
    end

  // Same for read requests
  rd_hold: assert property (@(posedge clk) disable iff (reset)
    rd_out_valid && !rd_out_ready |=> rd_out_valid && $stable(rd_out_packet))
    else
    begin
      $error("rd_out dropped or changed while stalled");
      fail_count++;
    end

  // And read responses
  rr_hold: assert property (@(posedge clk) disable iff (reset)
    rr_out_valid && !rr_out_ready |=> rr_out_valid && $stable(rr_out_packet))
    else
    begin
      $error("rr_out dropped or changed while stalled");
      fail_count++;
    end

  // Queues empty in reset
  reset_idle: assert property (@(posedge clk)
    reset |-> !wr_out_valid && !rd_out_valid && !rr_out_valid)
    else
    begin
      $error("output valid asserted during reset");
      fail_count++;
    end

endmodule

bind rx_top rx_top_asserts i_rx_top_asserts (.*);

`default_nettype wire

//--- sim/tb_rx_top.sv
// ======================================================================
// Testbench for the mesh receive distributor
// Random mesh and DMA traffic checked against a routing model
// ======================================================================

`timescale 1ns/10ps
`default_nettype none

module tb_rx_top;

  // Expected stream codes
  localparam int ST_NONE = 0;
  localparam int ST_WR   = 1;
  localparam int ST_RD   = 2;
  localparam int ST_RR   = 3;
  // Packets sent over all tests to size the watchdog
  localparam int N_PKTS      = 213;
  localparam int WATCHDOG_NS = N_PKTS * 40 * 10 + 1000;

  logic                   clk = 1'b0;
  logic                   reset;
  logic                   mmu_en;
  logic                   map_we;
  mesh_pkg::page_index_t  map_index;
  mesh_pkg::link_id_t     map_page;
  logic                   mesh_in_valid;
  logic                   mesh_in_ready;
  mesh_pkg::mesh_packet_t mesh_in_packet;
  logic                   dma_in_valid;
  logic                   dma_in_ready;
  mesh_pkg::mesh_packet_t dma_in_packet;
  logic                   wr_out_valid;
  logic                   wr_out_ready;
  mesh_pkg::mesh_packet_t wr_out_packet;
  logic                   rd_out_valid;
  logic                   rd_out_ready;
  mesh_pkg::mesh_packet_t rd_out_packet;
  logic                   rr_out_valid;
  logic                   rr_out_ready;
  mesh_pkg::mesh_packet_t rr_out_packet;

  // Scoreboards with mesh and DMA reads kept apart
  mesh_pkg::mesh_packet_t exp_wr[$];
  mesh_pkg::mesh_packet_t exp_rr[$];
  mesh_pkg::mesh_packet_t exp_rd_mesh[$];
  mesh_pkg::mesh_packet_t exp_rd_dma[$];
  mesh_pkg::link_id_t     map_mirror [mesh_pkg::MAP_ENTRIES];

  int unsigned mesh_state;
  int unsigned dma_state;
  int unsigned rdy_state;
  logic        stall_en;
  int          cyc = 0;
  int          errors = 0;
  int          checked = 0;
  int          dropped = 0;

  rx_top i_rx_top (.*);

  always #5 clk = ~clk;

  always @(posedge clk)
    cyc <= cyc + 1;

  function automatic int unsigned lcg(inout int unsigned state);
    state = state * 32'd1664525 + 32'd1013904223;
    return state;
  endfunction

  // Upper LCG bits only since the low bits are weak
  function automatic int unsigned rand_below(inout int unsigned st, input int unsigned n);
    return (lcg(st) >> 16) % n;
  endfunction

  // Kind 0 remote write, 1 write to own link, 2 read, 3 any of these
  function automatic mesh_pkg::mesh_packet_t rand_packet(inout int unsigned st,
      input int kind, input logic dma, input int seq);
    mesh_pkg::mesh_packet_t p;
    int k;
    k = (kind == 3) ? int'(rand_below(st, 3)) : kind;
    p.write    = (k != 2);
    p.datamode = 2'(lcg(st) >> 30);
    p.ctrlmode = 4'(lcg(st) >> 28);
    p.dstaddr  = lcg(st);
    p.srcaddr  = lcg(st);
    // Source flag and sequence number make packets unique
    p.data     = {dma, 15'(seq), 16'(lcg(st) >> 16)};
    if (k == 1)
    begin
      p.dstaddr[31:20] = mesh_pkg::LINK_ID;
      if (rand_below(st, 2) == 0)
        p.dstaddr[19:16] = mesh_pkg::READTAG_GROUP;
    end
    else if (k == 0 && p.dstaddr[31:20] == mesh_pkg::LINK_ID)
      p.dstaddr[20] = ~p.dstaddr[20];
    return p;
  endfunction

  // Reference model with translation then classification by type and target
  function automatic int route_ref(input mesh_pkg::mesh_packet_t pkt, input logic en,
      output mesh_pkg::mesh_packet_t xlat);
    xlat = pkt;
    if (en)
      xlat.dstaddr[31:20] = map_mirror[pkt.dstaddr[31:28]];
    if (!xlat.write)
      return ST_RD;
    if (xlat.dstaddr[31:20] != mesh_pkg::LINK_ID)
      return ST_WR;
    if (xlat.dstaddr[19:16] == mesh_pkg::READTAG_GROUP)
      return ST_RR;
    return ST_NONE;
  endfunction

  function automatic logic out_valid_of(input int stream);
    case (stream)
      ST_WR:   return wr_out_valid;
      ST_RD:   return rd_out_valid;
      default: return rr_out_valid;
    endcase
  endfunction

  task automatic compare_packet(input string name, input mesh_pkg::mesh_packet_t exp,
      input mesh_pkg::mesh_packet_t act);
    checked++;
    if (act !== exp)
    begin
      errors++;
      $display("FAIL time=%0t signal=%s expected=%h actual=%h", $time, name, exp, act);
    end
  endtask

  // Starts and ends on a falling edge and returns the accept cycle
  task automatic send(input logic dma, input mesh_pkg::mesh_packet_t pkt,
      input logic gaps, output int acc);
    int unsigned gap;
    gap = 0;
    if (gaps)
      gap = dma ? rand_below(dma_state, 3) : rand_below(mesh_state, 3);
    repeat (gap) @(negedge clk);
    if (dma)
    begin
      dma_in_valid  = 1'b1;
      dma_in_packet = pkt;
    end
    else
    begin
      mesh_in_valid  = 1'b1;
      mesh_in_packet = pkt;
    end
    @(posedge clk);
    while (!(dma ? dma_in_ready : mesh_in_ready))
      @(posedge clk);
    acc = cyc;
    @(negedge clk);
    if (dma)
      dma_in_valid = 1'b0;
    else
      mesh_in_valid = 1'b0;
  endtask

  task automatic burst(input logic dma, input int n, input int kind, input logic gaps);
    mesh_pkg::mesh_packet_t p;
    int acc;
    for (int i = 0; i < n; i++)
    begin
      if (dma)
        p = rand_packet(dma_state, kind, 1'b1, i);
      else
        p = rand_packet(mesh_state, kind, 1'b0, i);
      send(dma, p, gaps, acc);
    end
  endtask

  // Random remap entries with the own link ID now and then
  task automatic load_table();
    for (int i = 0; i < mesh_pkg::MAP_ENTRIES; i++)
    begin
      @(negedge clk);
      map_we    = 1'b1;
      map_index = 4'(i);
      map_page  = (rand_below(mesh_state, 4) == 0) ? mesh_pkg::LINK_ID
                                                  : 12'(lcg(mesh_state) >> 20);
    end
    @(negedge clk);
    map_we = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_wr.size() + exp_rr.size() + exp_rd_mesh.size() + exp_rd_dma.size() != 0
           && n < 3000)
    begin
      @(negedge clk);
      n++;
    end
    if (n == 3000)
    begin
      errors++;
      $display("Expected packets still outstanding at time %0t", $time);
    end
    repeat (4) @(negedge clk);
  endtask

  task automatic check_latency(input logic dma, input mesh_pkg::mesh_packet_t pkt,
      input int stream, input int exp_lat, input string name);
    int acc;
    int lat;
    lat = -1;
    send(dma, pkt, 1'b0, acc);
    for (int k = 0; k < 20 && lat < 0; k++)
    begin
      @(posedge clk);
      if (out_valid_of(stream))
        lat = cyc - acc;
    end
    if (lat < 0)
    begin
      errors++;
      $display("No packet reached %s in the latency test at time %0t", name, $time);
    end
    else if (lat != exp_lat)
    begin
      errors++;
      $display("FAIL time=%0t signal=%s latency expected=%0d actual=%0d",
               $time, name, exp_lat, lat);
    end
    @(negedge clk);
  endtask

  // Random ready low periods while stalling
  always @(negedge clk)
  begin
    if (stall_en)
    begin
      wr_out_ready = (rand_below(rdy_state, 4) == 0);
      rd_out_ready = (rand_below(rdy_state, 4) == 0);
      rr_out_ready = (rand_below(rdy_state, 4) == 0);
    end
    else
    begin
      wr_out_ready = 1'b1;
      rd_out_ready = 1'b1;
      rr_out_ready = 1'b1;
    end
  end

  // Accepted inputs into the expected queues
  always @(posedge clk)
  begin
    mesh_pkg::mesh_packet_t xlat;
    int st;
    if (!reset)
    begin
      if (mesh_in_valid && mesh_in_ready)
      begin
        st = route_ref(mesh_in_packet, mmu_en, xlat);
        case (st)
          ST_WR:   exp_wr.push_back(xlat);
          ST_RD:   exp_rd_mesh.push_back(xlat);
          ST_RR:   exp_rr.push_back(xlat);
          default: dropped++;
        endcase
      end
      if (dma_in_valid && dma_in_ready)
        exp_rd_dma.push_back(dma_in_packet);
      // Table write counts for later accepts only
      if (map_we)
        map_mirror[map_index] = map_page;
    end
  end

  // Output transfers against the expected queues
  always @(posedge clk)
  begin
    if (!reset)
    begin
      if (wr_out_valid && wr_out_ready)
      begin
        if (exp_wr.size() == 0)
        begin
          errors++;
          $display("Unexpected packet on wr_out at time %0t", $time);
        end
        else
          compare_packet("wr_out_packet", exp_wr.pop_front(), wr_out_packet);
      end
      if (rr_out_valid && rr_out_ready)
      begin
        if (exp_rr.size() == 0)
        begin
          errors++;
          $display("Unexpected packet on rr_out at time %0t", $time);
        end
        else
          compare_packet("rr_out_packet", exp_rr.pop_front(), rr_out_packet);
      end
      // Source flag in the data word picks the mesh or DMA order
      if (rd_out_valid && rd_out_ready)
      begin
        if (rd_out_packet.data[31])
        begin
          if (exp_rd_dma.size() == 0)
          begin
            errors++;
            $display("Unexpected DMA read on rd_out at time %0t", $time);
          end
          else
            compare_packet("rd_out_packet", exp_rd_dma.pop_front(), rd_out_packet);
        end
        else if (exp_rd_mesh.size() == 0)
        begin
          errors++;
          $display("Unexpected mesh read on rd_out at time %0t", $time);
        end
        else
          compare_packet("rd_out_packet", exp_rd_mesh.pop_front(), rd_out_packet);
      end
    end
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired at time %0t before the tests completed", $time);
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    int unsigned seed;
    mesh_pkg::mesh_packet_t p;
    seed       = 11310;
    mesh_state = seed;
    dma_state  = lcg(seed);
    rdy_state  = lcg(seed);
    reset          = 1'b1;
    mmu_en         = 1'b0;
    map_we         = 1'b0;
    map_index      = '0;
    map_page       = '0;
    mesh_in_valid  = 1'b0;
    mesh_in_packet = '0;
    dma_in_valid   = 1'b0;
    dma_in_packet  = '0;
    stall_en       = 1'b0;
    wr_out_ready   = 1'b1;
    rd_out_ready   = 1'b1;
    rr_out_ready   = 1'b1;
    // Identity mapping after reset
    for (int i = 0; i < mesh_pkg::MAP_ENTRIES; i++)
      map_mirror[i] = {4'(i), 8'h00};
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Remote writes without translation
    burst(1'b0, 20, 0, 1'b1);
    wait_drain();
    // Writes to own link give responses or drops
    burst(1'b0, 20, 1, 1'b1);
    wait_drain();
    // Mesh and DMA reads held back to back
    fork
      burst(1'b0, 20, 2, 1'b0);
      burst(1'b1, 20, 2, 1'b0);
    join
    wait_drain();
    // Random table with translated mixed traffic
    load_table();
    mmu_en = 1'b1;
    burst(1'b0, 40, 3, 1'b1);
    wait_drain();
    // Back-pressure fills the queues
    @(posedge clk);
    stall_en = 1'b1;
    @(negedge clk);
    fork
      burst(1'b0, 60, 3, 1'b1);
      burst(1'b1, 30, 2, 1'b1);
    join
    @(posedge clk);
    stall_en = 1'b0;
    @(negedge clk);
    wait_drain();

    // Single packets through an idle pipeline
    mmu_en = 1'b0;
    @(negedge clk);
    check_latency(1'b0, rand_packet(mesh_state, 0, 1'b0, 900), ST_WR, 3, "wr_out_valid");
    wait_drain();
    check_latency(1'b1, rand_packet(dma_state, 2, 1'b1, 901), ST_RD, 2, "rd_out_valid");
    wait_drain();
    p = rand_packet(mesh_state, 1, 1'b0, 902);
    p.dstaddr[19:16] = mesh_pkg::READTAG_GROUP;
    check_latency(1'b0, p, ST_RR, 3, "rr_out_valid");
    wait_drain();

    // Bound handshake assertions add their failures
    errors += i_rx_top.i_rx_top_asserts.fail_count;
    $display("Summary: %0d errors, %0d packets checked, %0d dropped",
             errors, checked, dropped);
    if (errors == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
